// File: verilog/CpuPkg.sv
`default_nettype none

package CpuPkg;

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int dataMemWords = 256;

  // Major opcodes
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opReg = 7'b0110011;

  // addi x0, x0, 0
  localparam logic [xlen-1:0] nopInstruction = {25'b0, opImm};

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOpT;

  typedef enum logic [1:0] {
    fromRegister,
    fromWriteback,
    fromMemory
  } forwardSelT;

endpackage

`default_nettype wire

// File: verilog/RegisterFile.sv
`default_nettype none

module RegisterFile import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  input wire [regIndexWidth-1:0] rs1Index,
  input wire [regIndexWidth-1:0] rs2Index,
  output logic [xlen-1:0] rs1Data,
  output logic [xlen-1:0] rs2Data,
  input wire writeEnable,
  input wire [regIndexWidth-1:0] writeIndex,
  input wire [xlen-1:0] writeData
);

  logic [xlen-1:0] registers [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (writeEnable && writeIndex != '0) begin
      registers[writeIndex] <= writeData;
    end
  end

  // New data bypasses the array in the write cycle
  always_comb begin
    if (rs1Index == '0) begin
      rs1Data = '0;
    end else if (writeEnable && writeIndex == rs1Index) begin
      rs1Data = writeData;
    end else begin
      rs1Data = registers[rs1Index];
    end
    if (rs2Index == '0) begin
      rs2Data = '0;
    end else if (writeEnable && writeIndex == rs2Index) begin
      rs2Data = writeData;
    end else begin
      rs2Data = registers[rs2Index];
    end
  end

endmodule

`default_nettype wire

// File: verilog/FetchStage.sv
`default_nettype none

module FetchStage import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  input wire [xlen-1:0] instrData,
  input wire stall,
  input wire branchTaken,
  input wire [xlen-1:0] branchTarget,
  output logic [xlen-1:0] instrAddr,
  output logic [xlen-1:0] idInstruction,
  output logic [xlen-1:0] idPc
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] nextPc;

  assign instrAddr = pc;

  always_comb begin
    if (branchTaken) begin
      nextPc = branchTarget;
    end else if (stall) begin
      nextPc = pc;
    end else begin
      nextPc = pc + xlen'(4);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // IF/ID barrier where flush wins over stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idInstruction <= nopInstruction;
      idPc <= '0;
    end else if (branchTaken) begin
      idInstruction <= nopInstruction;
    end else if (!stall) begin
      idInstruction <= instrData;
      idPc <= pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/DecodeStage.sv
`default_nettype none

module DecodeStage import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  input wire [xlen-1:0] idInstruction,
  input wire [xlen-1:0] idPc,
  input wire branchTaken,
  input wire wbRegWrite,
  input wire [regIndexWidth-1:0] wbRdIndex,
  input wire [xlen-1:0] wbData,
  output logic stall,
  output logic [xlen-1:0] exPc,
  output logic [xlen-1:0] exRs1Value,
  output logic [xlen-1:0] exRs2Value,
  output logic [regIndexWidth-1:0] exRs1Index,
  output logic [regIndexWidth-1:0] exRs2Index,
  output logic [regIndexWidth-1:0] exRdIndex,
  output logic [xlen-1:0] exImmediate,
  output aluOpT exAluOp,
  output logic exAluSrcImm,
  output logic exPcToAlu,
  output logic exLink,
  output logic exBranch,
  output logic exJumpRegister,
  output logic [2:0] exBranchFunct,
  output logic exMemRead,
  output logic exMemWrite,
  output logic exRegWrite
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic altFunct;
  logic [regIndexWidth-1:0] rs1Index;
  logic [regIndexWidth-1:0] rs2Index;
  logic [regIndexWidth-1:0] rdIndex;
  logic [xlen-1:0] rs1Data;
  logic [xlen-1:0] rs2Data;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [xlen-1:0] immB;
  logic [xlen-1:0] immU;
  logic [xlen-1:0] immJ;
  logic [xlen-1:0] immediate;
  aluOpT aluOp;
  logic aluSrcImm;
  logic pcToAlu;
  logic link;
  logic branch;
  logic jumpRegister;
  logic memRead;
  logic memWrite;
  logic regWrite;
  logic usesRs1;
  logic usesRs2;
  logic bubble;

  assign opcode = idInstruction[6:0];
  assign rdIndex = idInstruction[11:7];
  assign funct3 = idInstruction[14:12];
  assign rs1Index = idInstruction[19:15];
  assign rs2Index = idInstruction[24:20];
  assign altFunct = idInstruction[30];

  assign immI = {{20{idInstruction[31]}}, idInstruction[31:20]};
  assign immS = {{20{idInstruction[31]}}, idInstruction[31:25], idInstruction[11:7]};
  assign immB = {{19{idInstruction[31]}}, idInstruction[31], idInstruction[7],
                 idInstruction[30:25], idInstruction[11:8], 1'b0};
  assign immU = {idInstruction[31:12], 12'b0};
  assign immJ = {{11{idInstruction[31]}}, idInstruction[31], idInstruction[19:12],
                 idInstruction[20], idInstruction[30:21], 1'b0};

  RegisterFile registerFile (
    .clk(clk),
    .rstN(rstN),
    .rs1Index(rs1Index),
    .rs2Index(rs2Index),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .writeEnable(wbRegWrite),
    .writeIndex(wbRdIndex),
    .writeData(wbData)
  );

  // Subtract only exists in the register form
  function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt, input logic isReg);
    case (f3)
      3'b000: arithOp = (isReg && alt) ? aluSub : aluAdd;
      3'b001: arithOp = aluSll;
      3'b010: arithOp = aluSlt;
      3'b011: arithOp = aluSltu;
      3'b100: arithOp = aluXor;
      3'b101: arithOp = alt ? aluSra : aluSrl;
      3'b110: arithOp = aluOr;
      default: arithOp = aluAnd;
    endcase
  endfunction

  always_comb begin
    immediate = immI;
    aluOp = aluAdd;
    aluSrcImm = 1'b0;
    pcToAlu = 1'b0;
    link = 1'b0;
    branch = 1'b0;
    jumpRegister = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    usesRs1 = 1'b0;
    usesRs2 = 1'b0;
    case (opcode)
      opLui: begin
        immediate = immU;
        aluOp = aluPassB;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
      end
      opAuipc: begin
        immediate = immU;
        aluSrcImm = 1'b1;
        pcToAlu = 1'b1;
        regWrite = 1'b1;
      end
      opJal: begin
        immediate = immJ;
        pcToAlu = 1'b1;
        link = 1'b1;
        regWrite = 1'b1;
      end
      opJalr: begin
        pcToAlu = 1'b1;
        link = 1'b1;
        jumpRegister = 1'b1;
        regWrite = 1'b1;
        usesRs1 = 1'b1;
      end
      opBranch: begin
        immediate = immB;
        branch = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
      end
      opLoad: begin
        aluSrcImm = 1'b1;
        memRead = 1'b1;
        regWrite = 1'b1;
        usesRs1 = 1'b1;
      end
      opStore: begin
        immediate = immS;
        aluSrcImm = 1'b1;
        memWrite = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
      end
      opImm: begin
        aluOp = arithOp(funct3, altFunct, 1'b0);
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
        usesRs1 = 1'b1;
      end
      opReg: begin
        aluOp = arithOp(funct3, altFunct, 1'b1);
        regWrite = 1'b1;
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
      end
      default: begin
        regWrite = 1'b0;
      end
    endcase
  end

  // Load in execute feeding a source read here
  assign stall = exMemRead && (exRdIndex != '0) &&
                 ((usesRs1 && exRdIndex == rs1Index) || (usesRs2 && exRdIndex == rs2Index));

  assign bubble = branchTaken || stall;

  // ID/EX barrier
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exRegWrite <= 1'b0;
      exBranch <= 1'b0;
      exLink <= 1'b0;
    end else if (bubble) begin
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exRegWrite <= 1'b0;
      exBranch <= 1'b0;
      exLink <= 1'b0;
    end else begin
      exMemRead <= memRead;
      exMemWrite <= memWrite;
      exRegWrite <= regWrite;
      exBranch <= branch;
      exLink <= link;
    end
  end

  always_ff @(posedge clk) begin
    exPc <= idPc;
    exRs1Value <= rs1Data;
    exRs2Value <= rs2Data;
    exRs1Index <= rs1Index;
    exRs2Index <= rs2Index;
    exRdIndex <= rdIndex;
    exImmediate <= immediate;
    exAluOp <= aluOp;
    exAluSrcImm <= aluSrcImm;
    exPcToAlu <= pcToAlu;
    exJumpRegister <= jumpRegister;
    exBranchFunct <= funct3;
  end

endmodule

`default_nettype wire

// File: verilog/ExecuteStage.sv
`default_nettype none

module ExecuteStage import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  input wire [xlen-1:0] exPc,
  input wire [xlen-1:0] exRs1Value,
  input wire [xlen-1:0] exRs2Value,
  input wire [regIndexWidth-1:0] exRs1Index,
  input wire [regIndexWidth-1:0] exRs2Index,
  input wire [regIndexWidth-1:0] exRdIndex,
  input wire [xlen-1:0] exImmediate,
  input wire aluOpT exAluOp,
  input wire exAluSrcImm,
  input wire exPcToAlu,
  input wire exLink,
  input wire exBranch,
  input wire exJumpRegister,
  input wire [2:0] exBranchFunct,
  input wire exMemRead,
  input wire exMemWrite,
  input wire exRegWrite,
  input wire memRegWrite,
  input wire [regIndexWidth-1:0] memRdIndex,
  input wire [xlen-1:0] memAluResult,
  input wire wbRegWrite,
  input wire [regIndexWidth-1:0] wbRdIndex,
  input wire [xlen-1:0] wbData,
  output logic branchTaken,
  output logic [xlen-1:0] branchTarget,
  output logic [xlen-1:0] memAluResultOut,
  output logic [xlen-1:0] memStoreData,
  output logic memMemRead,
  output logic memMemWrite,
  output logic memRegWriteOut,
  output logic [regIndexWidth-1:0] memRdIndexOut
);

  localparam int shiftBits = $clog2(xlen);

  forwardSelT rs1Sel;
  forwardSelT rs2Sel;
  logic [xlen-1:0] rs1Fwd;
  logic [xlen-1:0] rs2Fwd;
  logic [xlen-1:0] operandA;
  logic [xlen-1:0] operandB;
  logic [xlen-1:0] aluResult;
  logic branchCond;

  // Youngest producer wins and x0 is never forwarded
  function automatic forwardSelT pickSource(input logic [regIndexWidth-1:0] index);
    if (index == '0) begin
      pickSource = fromRegister;
    end else if (memRegWrite && memRdIndex == index) begin
      pickSource = fromMemory;
    end else if (wbRegWrite && wbRdIndex == index) begin
      pickSource = fromWriteback;
    end else begin
      pickSource = fromRegister;
    end
  endfunction

  function automatic logic [xlen-1:0] forwardValue(input forwardSelT sel,
                                                   input logic [xlen-1:0] regValue);
    case (sel)
      fromMemory: forwardValue = memAluResult;
      fromWriteback: forwardValue = wbData;
      default: forwardValue = regValue;
    endcase
  endfunction

  always_comb begin
    rs1Sel = pickSource(exRs1Index);
    rs2Sel = pickSource(exRs2Index);
  end

  assign rs1Fwd = forwardValue(rs1Sel, exRs1Value);
  assign rs2Fwd = forwardValue(rs2Sel, exRs2Value);

  assign operandA = exPcToAlu ? exPc : rs1Fwd;
  // Links compute pc + 4
  assign operandB = exAluSrcImm ? exImmediate : (exLink ? xlen'(4) : rs2Fwd);

  always_comb begin
    case (exAluOp)
      aluAdd: aluResult = operandA + operandB;
      aluSub: aluResult = operandA - operandB;
      aluSll: aluResult = operandA << operandB[shiftBits-1:0];
      aluSlt: aluResult = xlen'($signed(operandA) < $signed(operandB));
      aluSltu: aluResult = xlen'(operandA < operandB);
      aluXor: aluResult = operandA ^ operandB;
      aluSrl: aluResult = operandA >> operandB[shiftBits-1:0];
      aluSra: aluResult = $signed(operandA) >>> operandB[shiftBits-1:0];
      aluOr: aluResult = operandA | operandB;
      aluAnd: aluResult = operandA & operandB;
      default: aluResult = operandB;
    endcase
  end

  always_comb begin
    case (exBranchFunct)
      3'b000: branchCond = rs1Fwd == rs2Fwd;
      3'b001: branchCond = rs1Fwd != rs2Fwd;
      3'b100: branchCond = $signed(rs1Fwd) < $signed(rs2Fwd);
      3'b101: branchCond = $signed(rs1Fwd) >= $signed(rs2Fwd);
      default: branchCond = 1'b0;
    endcase
  end

  assign branchTaken = exLink || (exBranch && branchCond);
  assign branchTarget = exJumpRegister ? ((rs1Fwd + exImmediate) & ~xlen'(1))
                                       : exPc + exImmediate;

  // EX/MEM barrier
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memMemRead <= 1'b0;
      memMemWrite <= 1'b0;
      memRegWriteOut <= 1'b0;
    end else begin
      memMemRead <= exMemRead;
      memMemWrite <= exMemWrite;
      memRegWriteOut <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    memAluResultOut <= aluResult;
    memStoreData <= rs2Fwd;
    memRdIndexOut <= exRdIndex;
  end

endmodule

`default_nettype wire

// File: verilog/MemoryStage.sv
`default_nettype none

module MemoryStage import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  input wire [xlen-1:0] aluResult,
  input wire [xlen-1:0] storeData,
  input wire memRead,
  input wire memWrite,
  input wire regWrite,
  input wire [regIndexWidth-1:0] rdIndex,
  output logic wbRegWrite,
  output logic [regIndexWidth-1:0] wbRdIndex,
  output logic [xlen-1:0] wbData
);

  localparam int wordBits = $clog2(dataMemWords);

  logic [xlen-1:0] dataMem [dataMemWords];
  logic [dataMemWords-1:0] wordWritten;
  logic [wordBits-1:0] wordIndex;
  logic [xlen-1:0] loadData;
  logic [xlen-1:0] wbLoadData;
  logic [xlen-1:0] wbAluData;
  logic wbMemToReg;

  assign wordIndex = aluResult[wordBits+1:2];
  // Words never stored read as zero
  assign loadData = wordWritten[wordIndex] ? dataMem[wordIndex] : '0;

  always_ff @(posedge clk) begin
    if (memWrite) begin
      dataMem[wordIndex] <= storeData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordWritten <= '0;
    end else if (memWrite) begin
      wordWritten[wordIndex] <= 1'b1;
    end
  end

  // MEM/WB barrier
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
      wbRdIndex <= '0;
    end else begin
      wbRegWrite <= regWrite && rdIndex != '0;
      wbMemToReg <= memRead;
      wbRdIndex <= rdIndex;
    end
  end

  always_ff @(posedge clk) begin
    wbLoadData <= loadData;
    wbAluData <= aluResult;
  end

  assign wbData = wbMemToReg ? wbLoadData : wbAluData;

endmodule

`default_nettype wire

// File: verilog/Cpu.sv
`default_nettype none

module Cpu import CpuPkg::*; (
  input wire clk,
  input wire rstN,
  output logic [xlen-1:0] instrAddr,
  input wire [xlen-1:0] instrData,
  output logic retireValid,
  output logic [regIndexWidth-1:0] retireRegister,
  output logic [xlen-1:0] retireData
);

  logic [xlen-1:0] idInstruction;
  logic [xlen-1:0] idPc;
  logic stall;
  logic branchTaken;
  logic [xlen-1:0] branchTarget;

  logic [xlen-1:0] exPc;
  logic [xlen-1:0] exRs1Value;
  logic [xlen-1:0] exRs2Value;
  logic [regIndexWidth-1:0] exRs1Index;
  logic [regIndexWidth-1:0] exRs2Index;
  logic [regIndexWidth-1:0] exRdIndex;
  logic [xlen-1:0] exImmediate;
  aluOpT exAluOp;
  logic exAluSrcImm;
  logic exPcToAlu;
  logic exLink;
  logic exBranch;
  logic exJumpRegister;
  logic [2:0] exBranchFunct;
  logic exMemRead;
  logic exMemWrite;
  logic exRegWrite;

  logic [xlen-1:0] memAluResult;
  logic [xlen-1:0] memStoreData;
  logic memMemRead;
  logic memMemWrite;
  logic memRegWrite;
  logic [regIndexWidth-1:0] memRdIndex;

  logic wbRegWrite;
  logic [regIndexWidth-1:0] wbRdIndex;
  logic [xlen-1:0] wbData;

  FetchStage fetchStage (
    .clk(clk),
    .rstN(rstN),
    .instrData(instrData),
    .stall(stall),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .instrAddr(instrAddr),
    .idInstruction(idInstruction),
    .idPc(idPc)
  );

  DecodeStage decodeStage (
    .clk(clk),
    .rstN(rstN),
    .idInstruction(idInstruction),
    .idPc(idPc),
    .branchTaken(branchTaken),
    .wbRegWrite(wbRegWrite),
    .wbRdIndex(wbRdIndex),
    .wbData(wbData),
    .stall(stall),
    .exPc(exPc),
    .exRs1Value(exRs1Value),
    .exRs2Value(exRs2Value),
    .exRs1Index(exRs1Index),
    .exRs2Index(exRs2Index),
    .exRdIndex(exRdIndex),
    .exImmediate(exImmediate),
    .exAluOp(exAluOp),
    .exAluSrcImm(exAluSrcImm),
    .exPcToAlu(exPcToAlu),
    .exLink(exLink),
    .exBranch(exBranch),
    .exJumpRegister(exJumpRegister),
    .exBranchFunct(exBranchFunct),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exRegWrite(exRegWrite)
  );

  ExecuteStage executeStage (
    .clk(clk),
    .rstN(rstN),
    .exPc(exPc),
    .exRs1Value(exRs1Value),
    .exRs2Value(exRs2Value),
    .exRs1Index(exRs1Index),
    .exRs2Index(exRs2Index),
    .exRdIndex(exRdIndex),
    .exImmediate(exImmediate),
    .exAluOp(exAluOp),
    .exAluSrcImm(exAluSrcImm),
    .exPcToAlu(exPcToAlu),
    .exLink(exLink),
    .exBranch(exBranch),
    .exJumpRegister(exJumpRegister),
    .exBranchFunct(exBranchFunct),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exRegWrite(exRegWrite),
    .memRegWrite(memRegWrite),
    .memRdIndex(memRdIndex),
    .memAluResult(memAluResult),
    .wbRegWrite(wbRegWrite),
    .wbRdIndex(wbRdIndex),
    .wbData(wbData),
    .branchTaken(branchTaken),
    .branchTarget(branchTarget),
    .memAluResultOut(memAluResult),
    .memStoreData(memStoreData),
    .memMemRead(memMemRead),
    .memMemWrite(memMemWrite),
    .memRegWriteOut(memRegWrite),
    .memRdIndexOut(memRdIndex)
  );

  MemoryStage memoryStage (
    .clk(clk),
    .rstN(rstN),
    .aluResult(memAluResult),
    .storeData(memStoreData),
    .memRead(memMemRead),
    .memWrite(memMemWrite),
    .regWrite(memRegWrite),
    .rdIndex(memRdIndex),
    .wbRegWrite(wbRegWrite),
    .wbRdIndex(wbRdIndex),
    .wbData(wbData)
  );

  // Writeback doubles as the retire port
  assign retireValid = wbRegWrite;
  assign retireRegister = wbRdIndex;
  assign retireData = wbData;

endmodule

`default_nettype wire

// File: bench/CpuTb.sv
`default_nettype none

module CpuTb import CpuPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int romWords = 256;
  localparam int romBits = $clog2(romWords);
  localparam int memBits = $clog2(dataMemWords);
  localparam int resetCycles = 10;
  localparam int timeoutCycles = 2000;
  localparam int drainCycles = 20;
  localparam int modelStepLimit = 4096;
  // Fetch runs at most two words past the final self loop
  localparam int fetchLimit = (romWords + 2) * 4;

  logic clk;
  logic rstN;
  logic [xlen-1:0] instrAddr;
  logic [xlen-1:0] instrData;
  logic retireValid;
  logic [regIndexWidth-1:0] retireRegister;
  logic [xlen-1:0] retireData;

  logic [xlen-1:0] rom [romWords];
  logic [31:0] lfsrState;
  logic [regIndexWidth-1:0] expRegQ [$];
  logic [xlen-1:0] expDataQ [$];
  int expectedCount = 0;
  int retireCount = 0;
  int mismatchCount = 0;
  int failureCount = 0;

  Cpu i_Cpu (
    .clk(clk),
    .rstN(rstN),
    .instrAddr(instrAddr),
    .instrData(instrData),
    .retireValid(retireValid),
    .retireRegister(retireRegister),
    .retireData(retireData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Only x0..x7 to make dependencies frequent
  function automatic logic [regIndexWidth-1:0] pickRegister();
    logic [31:0] bits;
    bits = randomBits(3);
    return regIndexWidth'(bits[2:0]);
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  task automatic generateProgram();
    int i;
    int kind;
    int skip;
    logic [31:0] bits;
    logic [2:0] f3;
    logic alt;
    logic [11:0] imm;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    i = 0;
    while (i < romWords - 1) begin
      kind = int'(randomBits(4));
      // Pairs and jumps need room before the final self loop
      if (kind >= 9 && i + 5 >= romWords - 1) begin
        kind = 0;
      end
      rd = pickRegister();
      rs1 = pickRegister();
      rs2 = pickRegister();
      bits = randomBits(21);
      f3 = bits[2:0];
      imm = {6'b0, bits[6:3], 2'b00};
      if (kind <= 3) begin
        alt = bits[3] && (f3 == 3'b000 || f3 == 3'b101);
        rom[i] = encR(alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd);
        i++;
      end else if (kind <= 6) begin
        if (f3 == 3'b001) begin
          imm = {7'b0, bits[8:4]};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, bits[3], 5'b0, bits[8:4]};
        end else begin
          imm = bits[14:3];
        end
        rom[i] = encI(imm, rs1, f3, rd, opImm);
        i++;
      end else if (kind == 7) begin
        rom[i] = {bits[19:0], rd, bits[20] ? opLui : opAuipc};
        i++;
      end else if (kind == 8) begin
        rom[i] = encI(imm, 5'd0, 3'b010, rd, opLoad);
        i++;
      end else if (kind == 9) begin
        // Store then load back from the same word
        rom[i] = encS(imm, rs2, 5'd0);
        rom[i + 1] = encI(imm, 5'd0, 3'b010, rd, opLoad);
        i += 2;
      end else if (kind == 10) begin
        // Load with its result used right away
        rom[i] = encI(imm, 5'd0, 3'b010, rd, opLoad);
        rom[i + 1] = encR(7'b0, rs2, rd, f3, rs1);
        i += 2;
      end else if (kind <= 12) begin
        case (bits[1:0])
          2'b00: f3 = 3'b000;
          2'b01: f3 = 3'b001;
          2'b10: f3 = 3'b100;
          default: f3 = 3'b101;
        endcase
        skip = int'(bits[3:2]) % 3 + 1;
        rom[i] = encB(13'((skip + 1) * 4), rs2, rs1, f3);
        i++;
      end else if (kind == 13) begin
        rom[i] = encJ(21'd8, rd);
        i++;
      end else if (kind == 14) begin
        rom[i] = encI(12'((i + 2) * 4), 5'd0, 3'b000, rd, opJalr);
        i++;
      end else begin
        rom[i] = encS(imm, rs2, 5'd0);
        i++;
      end
    end
    rom[romWords - 1] = encJ(21'd0, 5'd0);
  endtask

  function automatic logic [xlen-1:0] aluRef(input logic [2:0] f3, input logic alt,
                                             input logic [xlen-1:0] x,
                                             input logic [xlen-1:0] y);
    case (f3)
      3'b000: return alt ? x - y : x + y;
      3'b001: return x << y[4:0];
      3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011: return (x < y) ? 32'd1 : 32'd0;
      3'b100: return x ^ y;
      3'b101: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110: return x | y;
      default: return x & y;
    endcase
  endfunction

  // Instruction-set model that fills the expected write lists
  function automatic int runModel();
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] mem [dataMemWords];
    logic [xlen-1:0] pc;
    logic [xlen-1:0] nextPc;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] result;
    logic [2:0] f3;
    logic write;
    logic taken;
    logic done;
    int steps;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int w = 0; w < dataMemWords; w++) begin
      mem[w] = '0;
    end
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < modelStepLimit) begin
      instr = rom[pc[romBits+1:2]];
      f3 = instr[14:12];
      a = regs[instr[19:15]];
      b = regs[instr[24:20]];
      immI = {{20{instr[31]}}, instr[31:20]};
      immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      nextPc = pc + 32'd4;
      write = 1'b0;
      result = '0;
      if (instr == encJ(21'd0, 5'd0)) begin
        done = 1'b1;
      end else begin
        case (instr[6:0])
          opLui: begin
            result = {instr[31:12], 12'b0};
            write = 1'b1;
          end
          opAuipc: begin
            result = pc + {instr[31:12], 12'b0};
            write = 1'b1;
          end
          opJal: begin
            result = pc + 32'd4;
            nextPc = pc + immJ;
            write = 1'b1;
          end
          opJalr: begin
            result = pc + 32'd4;
            nextPc = (a + immI) & ~32'd1;
            write = 1'b1;
          end
          opBranch: begin
            case (f3)
              3'b000: taken = a == b;
              3'b001: taken = a != b;
              3'b100: taken = $signed(a) < $signed(b);
              3'b101: taken = $signed(a) >= $signed(b);
              default: taken = 1'b0;
            endcase
            if (taken) begin
              nextPc = pc + immB;
            end
          end
          opLoad: begin
            addr = a + immI;
            result = mem[addr[memBits+1:2]];
            write = 1'b1;
          end
          opStore: begin
            addr = a + immS;
            mem[addr[memBits+1:2]] = b;
          end
          opImm: begin
            result = aluRef(f3, f3 == 3'b101 && instr[30], a, immI);
            write = 1'b1;
          end
          opReg: begin
            result = aluRef(f3, instr[30], a, b);
            write = 1'b1;
          end
          default: write = 1'b0;
        endcase
        if (write && instr[11:7] != 5'd0) begin
          regs[instr[11:7]] = result;
          expRegQ.push_back(instr[11:7]);
          expDataQ.push_back(result);
        end
        pc = nextPc;
      end
      steps++;
    end
    return expRegQ.size();
  endfunction

  task automatic checkRegister(input logic [regIndexWidth-1:0] actual,
                               input logic [regIndexWidth-1:0] expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Error: retireRegister 0x%h, expected 0x%h at %0t", actual, expected, $time);
    end
  endtask

  task automatic checkData(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("Error: retireData 0x%h, expected 0x%h at %0t", actual, expected, $time);
    end
  endtask

  // Combinational ROM read once the new PC has settled
  always @(posedge clk) begin
    #1;
    if (rstN && (instrAddr[1:0] != 2'b00 || instrAddr >= xlen'(fetchLimit))) begin
      mismatchCount++;
      $display("Error: instrAddr 0x%h, expected aligned and below 0x%h at %0t",
               instrAddr, xlen'(fetchLimit), $time);
    end
    instrData = rom[instrAddr[romBits+1:2]];
  end

  always @(negedge clk) begin
    if (rstN && retireValid) begin
      retireCount++;
      if (retireRegister == '0) begin
        failureCount++;
        $display("A write to x0 appeared on the retire port at %0t", $time);
      end
      if (expRegQ.size() == 0) begin
        failureCount++;
        $display("A register write retired after the last expected one at %0t", $time);
      end else begin
        checkRegister(retireRegister, expRegQ.pop_front());
        checkData(retireData, expDataQ.pop_front());
      end
    end
  end

  initial begin
    int cycles;
    rstN = 1'b0;
    instrData = nopInstruction;
    lfsrState = 32'h92a8;
    generateProgram();
    expectedCount = runModel();
    for (int c = 0; c < resetCycles; c++) begin
      @(posedge clk);
    end
    #1 rstN = 1'b1;
    cycles = 0;
    while (retireCount < expectedCount && cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    if (retireCount < expectedCount) begin
      failureCount++;
      $display("Timeout: only %0d of %0d register writes retired", retireCount, expectedCount);
    end else begin
      // Nothing more may retire once the self loop is reached
      for (int c = 0; c < drainCycles; c++) begin
        @(posedge clk);
      end
    end
    $display("Done: %0d value errors, %0d other failures, %0d of %0d writes retired",
             mismatchCount, failureCount, retireCount, expectedCount);
    if (mismatchCount == 0 && failureCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/CpuPkg.sv
verilog/RegisterFile.sv
verilog/FetchStage.sv
verilog/DecodeStage.sv
verilog/ExecuteStage.sv
verilog/MemoryStage.sv
verilog/Cpu.sv
bench/CpuTb.sv

// File: Makefile
SIM := verilator
SIMFLAGS := --binary --timing -j 0
TOP := CpuTb
FILELIST := src.f
BUILDDIR := obj_dir
PASSTEXT := *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSTEXT)'

clean:
	rm -rf $(BUILDDIR)
